// File: verilog.f
+incdir+dv
hw/panelPkg.sv
hw/laneMemory.sv
hw/frameBuffer.sv
hw/axiPixelWriter.sv
hw/panelScanner.sv
hw/ledPanelTop.sv
dv/ledPanelTb.sv

// File: dv/panelRefModel.svh
// ------------------------------------------------------------------------
// shadow of the pixel memory with response and colour bit prediction
// entries stay unknown until the testbench writes them
// ------------------------------------------------------------------------
`ifndef PANEL_REF_MODEL_SVH
`define PANEL_REF_MODEL_SVH

// one RGB565 pixel per {subpanel, row, column}
logic [15:0] shadowMem [0:511];

// byte addresses with bits 11 and 10 clear are pixel space
function automatic logic isPixelAddr(input logic [11:0] addr);
    return addr[11:10] == 2'b00;
endfunction

// pixel space and the control word answer OKAY on writes
function automatic panelPkg::axiResp predictWriteResp(input logic [11:0] addr);
    if (isPixelAddr(addr) || addr == panelPkg::ControlAddr) begin
        return panelPkg::OKAY;
    end
    return panelPkg::SLVERR;
endfunction

// only the control word reads back
function automatic panelPkg::axiResp predictReadResp(input logic [11:0] addr);
    if (addr == panelPkg::ControlAddr) begin
        return panelPkg::OKAY;
    end
    return panelPkg::SLVERR;
endfunction

// strobe bit 0 is the low pixel byte, bit 1 the high one
function automatic void applyWrite(input logic [11:0] addr, input logic [15:0] data,
                                   input logic [3:0] strb);
    if (isPixelAddr(addr) && strb[0]) begin
        shadowMem[addr[9:1]][7:0] = data[7:0];
    end
    if (isPixelAddr(addr) && strb[1]) begin
        shadowMem[addr[9:1]][15:8] = data[15:8];
    end
endfunction

// {red, green, blue} bit of one plane with green taken one bit deeper
function automatic logic [2:0] expectedBits(input int half, input int col,
                                            input int row, input int plane);
    logic [15:0] pixel;
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
    pixel = shadowMem[half * 256 + row * 32 + col];
    red = pixel[15:11];
    green = pixel[10:5];
    blue = pixel[4:0];
    return {red[plane], green[plane + 1], blue[plane]};
endfunction

`endif

// File: dv/ledPanelTb.sv
// ------------------------------------------------------------------------
// drives ledPanelTop over AXI4-Lite and checks every shifted panel bit
// assumes the scan starts at row 0 plane 0 when the enable is first set
// ------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ledPanelTb;

    `include "panelRefModel.svh"

    localparam int FrameLatches = panelPkg::SubpanelRows * panelPkg::PlaneCount;
    // per row 5 planes of 32 fetch and shift pairs, blank and latch, then the holds
    localparam int FrameCycles = panelPkg::SubpanelRows * (panelPkg::PlaneCount
        * (2 * panelPkg::PanelColumns + 2) + panelPkg::PlaneHoldBase * 31);
    // about 8 cycles for each of 520 AXI accesses
    localparam int CycleLimit = 520 * 8 + 3 * FrameCycles + 100;

    logic ClockA;
    logic rstN;
    logic AWVALID, AWREADY, WVALID, WREADY, BVALID, BREADY;
    logic ARVALID, ARREADY, RVALID, RREADY;
    logic [panelPkg::AxiAddrBits-1:0] AWADDR, ARADDR;
    logic [31:0] WDATA, RDATA;
    logic [3:0] WSTRB;
    panelPkg::axiResp BRESP, RRESP;
    logic R1, G1, B1, R2, G2, B2, ShiftClock, PanelLatch, PanelBlank;
    logic [panelPkg::RowBits-1:0] RowAddr;

    integer seed = 32'h6e4e_c67e;
    int cycleCount = 0;
    int shiftCount = 0;
    int latchCount = 0;
    int scanErrors = 0;
    int idleErrors = 0;
    int testErrors = 0;
    int totalErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    logic scanOn = 1'b0;
    // colour bits {R, G, B} per column of the row being shifted
    logic [2:0] topRow [0:panelPkg::PanelColumns-1];
    logic [2:0] bottomRow [0:panelPkg::PanelColumns-1];

    ledPanelTop ledPanelTop_i (.*);

    initial begin
        ClockA = 1'b0;
        forever #10 ClockA = ~ClockA;
    end

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        testErrors = testErrors + 1;
    endtask

    task automatic finishTest(input string name);
        testsRun = testsRun + 1;
        totalErrors = totalErrors + testErrors;
        if (testErrors != 0) begin
            testsFailed = testsFailed + 1;
        end
        $display("test %s: %s, %0d errors", name, (testErrors == 0) ? "passed" : "FAILED",
                 testErrors);
        testErrors = 0;
    endtask

    // AW and W go out together and the shadow follows at once
    task automatic startWrite(input logic [11:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        AWVALID <= 1'b1;
        AWADDR <= addr;
        WVALID <= 1'b1;
        WDATA <= data;
        WSTRB <= strb;
        applyWrite(addr, data[15:0], strb);
    endtask

    task automatic waitWriteAccept();
        @(posedge ClockA);
        while (!(AWREADY === 1'b1 && WREADY === 1'b1)) @(posedge ClockA);
        AWVALID <= 1'b0;
        WVALID <= 1'b0;
    endtask

    task automatic waitResponse(output panelPkg::axiResp resp);
        BREADY <= 1'b1;
        @(posedge ClockA);
        while (BVALID !== 1'b1) @(posedge ClockA);
        resp = BRESP;
        BREADY <= 1'b0;
    endtask

    task automatic axiWrite(input string name, input logic [11:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
        panelPkg::axiResp resp;
        startWrite(addr, data, strb);
        waitWriteAccept();
        waitResponse(resp);
        if (resp !== predictWriteResp(addr)) reportMismatch(name, predictWriteResp(addr), resp);
    endtask

    task automatic axiRead(input string name, input logic [11:0] addr,
                           input logic [31:0] expData);
        ARVALID <= 1'b1;
        ARADDR <= addr;
        @(posedge ClockA);
        while (ARREADY !== 1'b1) @(posedge ClockA);
        ARVALID <= 1'b0;
        RREADY <= 1'b1;
        @(posedge ClockA);
        while (RVALID !== 1'b1) @(posedge ClockA);
        RREADY <= 1'b0;
        if (RRESP !== predictReadResp(addr)) reportMismatch(name, predictReadResp(addr), RRESP);
        if (RDATA !== expData) reportMismatch(name, expData, RDATA);
    endtask

    // colour lines are steady for the whole ShiftClock cycle
    always @(posedge ClockA) begin
        if (rstN && PanelLatch === 1'b1) begin
            shiftCount <= 0;
        end else if (rstN && ShiftClock === 1'b1) begin
            if (shiftCount < panelPkg::PanelColumns) begin
                topRow[shiftCount] <= {R1, G1, B1};
                bottomRow[shiftCount] <= {R2, G2, B2};
            end
            shiftCount <= shiftCount + 1;
        end
    end

    // one row per latch with the plane counted up from the first latch
    always @(posedge ClockA) begin : compareRow
        int plane;
        int row;
        logic [2:0] expTop;
        logic [2:0] expBottom;
        string where;
        if (rstN && PanelLatch === 1'b1 && latchCount < FrameLatches) begin
            plane = latchCount % panelPkg::PlaneCount;
            row = (latchCount / panelPkg::PlaneCount) % panelPkg::SubpanelRows;
            if (shiftCount != panelPkg::PanelColumns || RowAddr !== row) begin
                $display("[ERROR] full scan: expected %0d shifts row %0d, actual %0d row %0d",
                         panelPkg::PanelColumns, row, shiftCount, RowAddr);
                scanErrors = scanErrors + 1;
            end
            for (int col = 0; col < panelPkg::PanelColumns; col++) begin
                expTop = expectedBits(0, col, row, plane);
                expBottom = expectedBits(1, col, row, plane);
                if (topRow[col] !== expTop || bottomRow[col] !== expBottom) begin
                    where = $sformatf("row %0d plane %0d col %0d", row, plane, col);
                    $display("[ERROR] full scan %s: expected %b %b, actual %b %b",
                             where, expTop, expBottom, topRow[col], bottomRow[col]);
                    scanErrors = scanErrors + 1;
                end
            end
        end
        if (rstN && PanelLatch === 1'b1) begin
            latchCount <= latchCount + 1;
        end
    end

    // panel must stay dark and quiet until the scan is enabled
    always @(posedge ClockA) begin
        if (rstN && !scanOn && (PanelBlank !== 1'b1 || ShiftClock !== 1'b0)) begin
            $display("[ERROR] idle outputs: expected blank 1 shift 0, actual blank %b shift %b",
                     PanelBlank, ShiftClock);
            idleErrors = idleErrors + 1;
        end
    end

    initial begin
        while (cycleCount < CycleLimit) begin
            @(posedge ClockA);
            cycleCount = cycleCount + 1;
        end
        $display("timeout: run did not complete within %0d cycles", CycleLimit);
        $display("Finished with errors");
        $finish;
    end

    initial begin : mainSequence
        logic [11:0] addr;
        logic [11:0] addrB;
        logic [15:0] pixel;
        panelPkg::axiResp heldResp;
        panelPkg::axiResp resp;
        rstN = 1'b0;
        AWVALID = 1'b0;
        AWADDR = '0;
        WVALID = 1'b0;
        WDATA = '0;
        WSTRB = '0;
        BREADY = 1'b0;
        ARVALID = 1'b0;
        ARADDR = '0;
        RREADY = 1'b0;
        repeat (3) @(posedge ClockA);
        rstN <= 1'b1;
        @(posedge ClockA);

        // every pixel gets a random value
        for (int i = 0; i < 512; i++) begin
            pixel = $random(seed);
            axiWrite("pixel fill", 12'(i * 2), {16'hdead, pixel}, 4'b0011);
        end
        finishTest("pixel fill");

        // guard bit set must not reach memory
        axiWrite("decode errors", 12'h40a, 32'h0000_ffff, 4'b0011);
        axiRead("decode errors", 12'h002, 32'h0);
        finishTest("decode errors");

        // inverted data so every strobed byte changes
        for (int i = 0; i < 3; i++) begin
            addr = 12'(((i * 173) % 512) * 2);
            axiWrite("byte strobes", addr, {16'h0, ~shadowMem[addr[9:1]]}, 4'(i + 1));
        end
        finishTest("byte strobes");

        // pixel write waits behind an unread decode error response
        addr = 12'h502;
        addrB = 12'h302;
        startWrite(addr, {16'h0, ~shadowMem[addr[9:1]]}, 4'b0011);
        waitWriteAccept();
        startWrite(addrB, {16'h0, ~shadowMem[addrB[9:1]]}, 4'b0011);
        @(posedge ClockA);
        heldResp = BRESP;
        if (heldResp !== predictWriteResp(addr)) begin
            reportMismatch("back-pressure", predictWriteResp(addr), heldResp);
        end
        repeat (6) begin
            @(posedge ClockA);
            if (BVALID !== 1'b1) reportMismatch("back-pressure BVALID", 1, BVALID);
            if (BRESP !== heldResp) reportMismatch("back-pressure BRESP", heldResp, BRESP);
            if ({AWREADY, WREADY} !== 2'b00) begin
                reportMismatch("back-pressure ready", 0, {AWREADY, WREADY});
            end
        end
        waitResponse(resp);
        waitWriteAccept();
        waitResponse(resp);
        if (resp !== predictWriteResp(addrB)) begin
            reportMismatch("back-pressure", predictWriteResp(addrB), resp);
        end
        finishTest("back-pressure");

        // reset value, then start the scan and read it back
        axiRead("control register", panelPkg::ControlAddr, 32'h0);
        scanOn <= 1'b1;
        axiWrite("control register", panelPkg::ControlAddr, 32'h1, 4'b0001);
        axiRead("control register", panelPkg::ControlAddr, 32'h1);
        finishTest("control register");
        testErrors = idleErrors;
        finishTest("idle outputs");

        while (latchCount < FrameLatches) @(posedge ClockA);
        testErrors = scanErrors;
        finishTest("full scan");

        $display("summary: %0d tests, %0d failed, %0d errors", testsRun, testsFailed, totalErrors);
        if (totalErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/ledPanelTop.sv
// ------------------------------------------------------------------------
// AXI4-Lite pixel writer, lane frame buffer and scanner on one clock
// ------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ledPanelTop (
    input  wire                                 ClockA,
    input  wire                                 rstN,
    // AXI4-Lite slave
    input  wire                                 AWVALID,
    output logic                                AWREADY,
    input  wire [panelPkg::AxiAddrBits-1:0]     AWADDR,
    input  wire                                 WVALID,
    output logic                                WREADY,
    input  wire [31:0]                          WDATA,
    input  wire [3:0]                           WSTRB,
    output logic                                BVALID,
    input  wire                                 BREADY,
    output panelPkg::axiResp                    BRESP,
    input  wire                                 ARVALID,
    output logic                                ARREADY,
    input  wire [panelPkg::AxiAddrBits-1:0]     ARADDR,
    output logic                                RVALID,
    input  wire                                 RREADY,
    output logic [31:0]                         RDATA,
    output panelPkg::axiResp                    RRESP,
    // panel pins
    output logic                                R1,
    output logic                                G1,
    output logic                                B1,
    output logic                                R2,
    output logic                                G2,
    output logic                                B2,
    output logic                                ShiftClock,
    output logic                                PanelLatch,
    output logic                                PanelBlank,
    output logic [panelPkg::RowBits-1:0]        RowAddr
);

    logic pixelWrEn;
    logic [panelPkg::LaneAddrBits:0] pixelAddr;
    logic [15:0] pixelData;
    logic [1:0] pixelByteEn;
    logic scanEnable;
    logic [panelPkg::LaneAddrBits-1:0] readAddr;
    logic [31:0] readData;

    axiPixelWriter axiPixelWriter_i (
        .ClockA(ClockA), .rstN(rstN),
        .AWVALID(AWVALID), .AWREADY(AWREADY), .AWADDR(AWADDR),
        .WVALID(WVALID), .WREADY(WREADY), .WDATA(WDATA), .WSTRB(WSTRB),
        .BVALID(BVALID), .BREADY(BREADY), .BRESP(BRESP),
        .ARVALID(ARVALID), .ARREADY(ARREADY), .ARADDR(ARADDR),
        .RVALID(RVALID), .RREADY(RREADY), .RDATA(RDATA), .RRESP(RRESP),
        .PixelWrEn(pixelWrEn), .PixelAddr(pixelAddr), .PixelData(pixelData),
        .PixelByteEn(pixelByteEn), .ScanEnable(scanEnable)
    );

    // scanner reads one column of both halves per access
    frameBuffer frameBuffer_i (
        .ClockA(ClockA), .rstN(rstN),
        .PixelWrEn(pixelWrEn), .PixelAddr(pixelAddr), .PixelData(pixelData),
        .PixelByteEn(pixelByteEn), .ReadAddr(readAddr), .ReadData(readData)
    );

    panelScanner panelScanner_i (
        .ClockA(ClockA), .rstN(rstN), .ScanEnable(scanEnable),
        .ReadAddr(readAddr), .ReadData(readData),
        .R1(R1), .G1(G1), .B1(B1), .R2(R2), .G2(G2), .B2(B2),
        .ShiftClock(ShiftClock), .PanelLatch(PanelLatch),
        .PanelBlank(PanelBlank), .RowAddr(RowAddr)
    );

endmodule

`default_nettype wire

// File: hw/panelScanner.sv
// ------------------------------------------------------------------------
// scans both halves at once, 5 bit planes per row, lit only in Hold
// colour lines are valid while ShiftClock is high; idles at a row start
// ------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module panelScanner (
    input  wire                                 ClockA,
    input  wire                                 rstN,
    input  wire                                 ScanEnable,
    output logic [panelPkg::LaneAddrBits-1:0]   ReadAddr,
    input  wire [31:0]                          ReadData,
    output logic                                R1,
    output logic                                G1,
    output logic                                B1,
    output logic                                R2,
    output logic                                G2,
    output logic                                B2,
    output logic                                ShiftClock,
    output logic                                PanelLatch,
    output logic                                PanelBlank,
    output logic [panelPkg::RowBits-1:0]        RowAddr
);

    panelPkg::scanState state;
    logic [panelPkg::ColumnBits-1:0] colCnt;
    logic [panelPkg::RowBits-1:0] rowCnt;
    logic [panelPkg::PlaneBits-1:0] planeCnt;
    logic [panelPkg::HoldCountBits-1:0] holdCnt;
    logic [2:0] topRgb;
    logic [2:0] bottomRgb;
    logic shiftNow;

    // pick the plane bit of each colour from an RGB565 word
    function automatic logic [2:0] planeColour(
        input logic [15:0] pixel,
        input logic [panelPkg::PlaneBits-1:0] plane
    );
        logic [2:0] rgb;
        // red in 15:11
        rgb[2] = pixel[11 + plane];
        // green in 10:5, its lsb is skipped
        rgb[1] = pixel[6 + plane];
        rgb[0] = pixel[plane];
        return rgb;
    endfunction

    // read address is {row, column}, data comes back in Shift
    assign ReadAddr = {rowCnt, colCnt};
    assign shiftNow = (state == panelPkg::Shift);

    assign topRgb = planeColour(ReadData[15:0], planeCnt);
    assign bottomRgb = planeColour(ReadData[31:16], planeCnt);
    // colour lines stay low outside Shift
    assign R1 = shiftNow && topRgb[2];
    assign G1 = shiftNow && topRgb[1];
    assign B1 = shiftNow && topRgb[0];
    assign R2 = shiftNow && bottomRgb[2];
    assign G2 = shiftNow && bottomRgb[1];
    assign B2 = shiftNow && bottomRgb[0];

    assign ShiftClock = shiftNow;
    assign PanelLatch = (state == panelPkg::Latch);
    // display lit only during the plane hold
    assign PanelBlank = (state != panelPkg::Hold);

    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            state <= panelPkg::Fetch;
            colCnt <= '0;
            rowCnt <= '0;
            planeCnt <= '0;
            holdCnt <= '0;
            RowAddr <= '0;
        end else begin
            case (state)
                panelPkg::Fetch: begin
                    // wait here at a row start while the scan is disabled
                    if (ScanEnable || colCnt != '0 || planeCnt != '0) begin
                        state <= panelPkg::Shift;
                    end
                end
                panelPkg::Shift: begin
                    if (colCnt == panelPkg::ColumnBits'(panelPkg::PanelColumns - 1)) begin
                        colCnt <= '0;
                        state <= panelPkg::Blank;
                    end else begin
                        colCnt <= colCnt + 1'b1;
                        state <= panelPkg::Fetch;
                    end
                end
                panelPkg::Blank: begin
                    // row address follows the row just shifted in
                    RowAddr <= rowCnt;
                    state <= panelPkg::Latch;
                end
                panelPkg::Latch: begin
                    // hold is PlaneHoldBase << plane cycles
                    holdCnt <= panelPkg::HoldCountBits'(
                        (panelPkg::PlaneHoldBase << planeCnt) - 1);
                    state <= panelPkg::Hold;
                end
                panelPkg::Hold: begin
                    if (holdCnt == '0) begin
                        state <= panelPkg::Fetch;
                        if (planeCnt == panelPkg::PlaneBits'(panelPkg::PlaneCount - 1)) begin
                            planeCnt <= '0;
                            if (rowCnt == panelPkg::RowBits'(panelPkg::SubpanelRows - 1)) begin
                                rowCnt <= '0;
                            end else begin
                                rowCnt <= rowCnt + 1'b1;
                            end
                        end else begin
                            planeCnt <= planeCnt + 1'b1;
                        end
                    end else begin
                        holdCnt <= holdCnt - 1'b1;
                    end
                end
                default: state <= panelPkg::Fetch;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/axiPixelWriter.sv
// ------------------------------------------------------------------------
// AXI4-Lite slave, no bursts; AW and W must both be valid to be accepted
// pixel space is write-only, reads other than the control word get SLVERR
// ------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module axiPixelWriter (
    input  wire                                     ClockA,
    input  wire                                     rstN,
    // write address and data
    input  wire                                     AWVALID,
    output logic                                    AWREADY,
    input  wire [panelPkg::AxiAddrBits-1:0]         AWADDR,
    input  wire                                     WVALID,
    output logic                                    WREADY,
    input  wire [31:0]                              WDATA,
    input  wire [3:0]                               WSTRB,
    // write response
    output logic                                    BVALID,
    input  wire                                     BREADY,
    output panelPkg::axiResp                        BRESP,
    // read side, control register only
    input  wire                                     ARVALID,
    output logic                                    ARREADY,
    input  wire [panelPkg::AxiAddrBits-1:0]         ARADDR,
    output logic                                    RVALID,
    input  wire                                     RREADY,
    output logic [31:0]                             RDATA,
    output panelPkg::axiResp                        RRESP,
    // frame buffer write port
    output logic                                    PixelWrEn,
    output logic [panelPkg::LaneAddrBits:0]         PixelAddr,
    output logic [15:0]                             PixelData,
    output logic [1:0]                              PixelByteEn,
    output logic                                    ScanEnable
);

    logic awReadyQ;
    logic wrHandshake;
    logic rdHandshake;
    logic wrIsPixel;
    logic wrIsControl;
    logic rdIsControl;

    // one ready pulse serves both AW and W
    assign AWREADY = awReadyQ;
    assign WREADY = awReadyQ;
    // valids hold their payload, so the ready pulse always meets them
    assign wrHandshake = awReadyQ && AWVALID && WVALID;
    assign rdHandshake = ARREADY && ARVALID;

    // pixel space is everything with the guard bit and above clear
    assign wrIsPixel = (AWADDR[panelPkg::AxiAddrBits-1:panelPkg::AddrGuardBit] == '0);
    assign wrIsControl = (AWADDR == panelPkg::ControlAddr);
    assign rdIsControl = (ARADDR == panelPkg::ControlAddr);

    // buffer write request, valid only in the handshake cycle
    assign PixelWrEn = wrHandshake && wrIsPixel;
    // {subpanel, row, column} straight out of the byte address
    assign PixelAddr = AWADDR[panelPkg::AddrSubpanelBit:panelPkg::AddrColumnLsb];
    assign PixelData = WDATA[15:0];
    assign PixelByteEn = WSTRB[1:0];

    // handshake and response control
    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            awReadyQ <= 1'b0;
            BVALID <= 1'b0;
            ARREADY <= 1'b0;
            RVALID <= 1'b0;
            ScanEnable <= 1'b0;
        end else begin
            // no new write while a response is still pending
            awReadyQ <= AWVALID && WVALID && !BVALID && !awReadyQ;
            if (wrHandshake) begin
                BVALID <= 1'b1;
            end else if (BREADY) begin
                BVALID <= 1'b0;
            end
            ARREADY <= ARVALID && !RVALID && !ARREADY;
            if (rdHandshake) begin
                RVALID <= 1'b1;
            end else if (RREADY) begin
                RVALID <= 1'b0;
            end
            // control word, low byte strobe guards the enable bit
            if (wrHandshake && wrIsControl && WSTRB[0]) begin
                ScanEnable <= WDATA[panelPkg::ScanEnableBit];
            end
        end
    end

    // response payload, held until the next handshake
    always_ff @(posedge ClockA) begin
        if (wrHandshake) begin
            BRESP <= (wrIsPixel || wrIsControl) ? panelPkg::OKAY : panelPkg::SLVERR;
        end
        if (rdHandshake) begin
            RDATA <= '0;
            RRESP <= panelPkg::SLVERR;
            if (rdIsControl) begin
                RDATA[panelPkg::ScanEnableBit] <= ScanEnable;
                RRESP <= panelPkg::OKAY;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/frameBuffer.sv
// ------------------------------------------------------------------------
// four byte lanes split by subpanel and byte; writes land a cycle late
// read data order low to high: top lo, top hi, bottom lo, bottom hi
// ------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module frameBuffer (
    input  wire                                 ClockA,
    input  wire                                 rstN,
    input  wire                                 PixelWrEn,
    // {subpanel, row, column}
    input  wire [panelPkg::LaneAddrBits:0]      PixelAddr,
    input  wire [15:0]                          PixelData,
    input  wire [1:0]                           PixelByteEn,
    input  wire [panelPkg::LaneAddrBits-1:0]    ReadAddr,
    output logic [31:0]                         ReadData
);

    logic [panelPkg::LaneCount-1:0] laneWrEn;
    logic [panelPkg::LaneCount-1:0] laneWrEnQ;
    logic [panelPkg::LaneAddrBits-1:0] wrAddrQ;
    logic [15:0] wrDataQ;

    // register the write request to break the decode path
    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            laneWrEnQ <= '0;
        end else begin
            laneWrEnQ <= laneWrEn;
        end
    end

    always_ff @(posedge ClockA) begin
        wrAddrQ <= PixelAddr[panelPkg::LaneAddrBits-1:0];
        wrDataQ <= PixelData;
    end

    genvar lane;
    generate
        for (lane = 0; lane < panelPkg::LaneCount; lane = lane + 1) begin : gLane
            // upper lane index picks the half, lower one the byte
            assign laneWrEn[lane] = PixelWrEn
                && (PixelAddr[panelPkg::LaneAddrBits] == lane / 2)
                && PixelByteEn[lane % 2];

            laneMemory laneMemory_i (
                .ClockA (ClockA),
                .rstN   (rstN),
                .WrEn   (laneWrEnQ[lane]),
                .WrAddr (wrAddrQ),
                .RdAddr (ReadAddr),
                .WrData (wrDataQ[(lane % 2) * panelPkg::LaneWidth +: panelPkg::LaneWidth]),
                .RdData (ReadData[lane * panelPkg::LaneWidth +: panelPkg::LaneWidth])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: hw/laneMemory.sv
// ------------------------------------------------------------------------
// one byte lane, simple dual port; read during write returns old data
// ------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module laneMemory (
    input  wire                                 ClockA,
    input  wire                                 rstN,
    input  wire                                 WrEn,
    input  wire [panelPkg::LaneAddrBits-1:0]    WrAddr,
    input  wire [panelPkg::LaneAddrBits-1:0]    RdAddr,
    input  wire [panelPkg::LaneWidth-1:0]       WrData,
    output logic [panelPkg::LaneWidth-1:0]      RdData
);

    logic [panelPkg::LaneWidth-1:0] mem [0:(1 << panelPkg::LaneAddrBits)-1];

    always_ff @(posedge ClockA) begin
        if (WrEn) begin
            mem[WrAddr] <= WrData;
        end
    end

    // registered read port, one cycle latency
    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            RdData <= '0;
        end else begin
            RdData <= mem[RdAddr];
        end
    end

endmodule

`default_nettype wire

// File: hw/panelPkg.sv
// ------------------------------------------------------------------------
// geometry, address map and shared enums for the 32x16 two-half panel
// pixel memory is write-only over AXI; only the control word reads back
// ------------------------------------------------------------------------
`default_nettype none

package panelPkg;

    // panel geometry, one half is 8 rows of 32 columns
    localparam int PanelColumns = 32;
    localparam int SubpanelRows = 8;
    localparam int ColumnBits = 5;
    localparam int RowBits = 3;

    // lane depth index is {row, column}
    localparam int LaneAddrBits = 8;
    // 2 subpanels times 2 bytes per pixel
    localparam int LaneCount = 4;
    localparam int LaneWidth = 8;

    // bit planes and binary weighted hold
    localparam int PlaneCount = 5;
    localparam int PlaneBits = 3;
    localparam int PlaneHoldBase = 4;
    // longest hold is PlaneHoldBase << 4, i.e. 64 cycles
    localparam int HoldCountBits = 7;

    // AXI address map
    localparam int AxiAddrBits = 12;
    localparam logic [AxiAddrBits-1:0] ControlAddr = 12'h800;
    localparam int ScanEnableBit = 0;
    // pixel byte address fields, bits above the guard bit must be zero
    localparam int AddrGuardBit = 10;
    localparam int AddrSubpanelBit = 9;
    localparam int AddrColumnLsb = 1;

    typedef enum logic [1:0] {
        OKAY = 2'b00,
        SLVERR = 2'b10
    } axiResp;

    typedef enum logic [2:0] {
        Fetch,
        Shift,
        Blank,
        Latch,
        Hold
    } scanState;

endpackage

`default_nettype wire
